// ==== tb.f ====
design/exec_pkg.sv
design/alu.sv
design/alu_ctrl.sv
design/main_decode.sv
design/reg_file.sv
design/exec_stage.sv
design/exec_core.sv
bench/exec_core_tb.sv

// ==== bench/exec_core_tb.sv ====
// execute core testbench
`timescale 1ns/100ps

module exec_core_tb
  import exec_pkg::*;
();

  typedef struct packed {
    wb_t     wb;
    store_t  st;
    branch_t br;
  } expect_t;

  logic        clk;
  logic        rst;
  logic [31:0] instr;
  logic        instr_valid;
  wb_t         wb;
  store_t      st;
  branch_t     br;

  expect_t     exp_now;
  expect_t     exp_d1;
  expect_t     exp_d2;
  logic [31:0] shadow [0:31]; // architectural register model
  int          seed = 32'h6c81;
  int          errors = 0;
  int          issued = 0;
  int          cycles = 0;
  int          test_err0 = 0;
  int          tests_run = 0;
  int          tests_bad = 0;

  exec_core #(
    .xlen (32)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .wb          (wb),
    .st          (st),
    .br          (br)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected result rides two edges behind its instruction
  always @(posedge clk) begin
    if (rst) begin
      exp_d1 <= '0;
      exp_d2 <= '0;
    end else begin
      exp_d1 <= exp_now;
      exp_d2 <= exp_d1;
    end
  end

  task automatic report_err(string name, logic [31:0] exp_val, logic [31:0] got_val);
    errors++;
    $display("error at %0t ns: %s expected %h got %h", $time, name, exp_val, got_val);
  endtask

  a_wb_valid: assert property (@(posedge clk) disable iff (rst) wb.valid == exp_d2.wb.valid)
    else report_err("wb.valid", $sampled(exp_d2.wb.valid), $sampled(wb.valid));
  a_wb_rd: assert property (@(posedge clk) disable iff (rst)
    exp_d2.wb.valid |-> wb.rd == exp_d2.wb.rd)
    else report_err("wb.rd", $sampled(exp_d2.wb.rd), $sampled(wb.rd));
  a_wb_data: assert property (@(posedge clk) disable iff (rst)
    exp_d2.wb.valid |-> wb.data == exp_d2.wb.data)
    else report_err("wb.data", $sampled(exp_d2.wb.data), $sampled(wb.data));
  a_st_we: assert property (@(posedge clk) disable iff (rst) st.we == exp_d2.st.we)
    else report_err("st.we", $sampled(exp_d2.st.we), $sampled(st.we));
  a_st_addr: assert property (@(posedge clk) disable iff (rst)
    exp_d2.st.we |-> st.addr == exp_d2.st.addr)
    else report_err("st.addr", $sampled(exp_d2.st.addr), $sampled(st.addr));
  a_st_wdata: assert property (@(posedge clk) disable iff (rst)
    exp_d2.st.we |-> st.wdata == exp_d2.st.wdata)
    else report_err("st.wdata", $sampled(exp_d2.st.wdata), $sampled(st.wdata));
  a_br_valid: assert property (@(posedge clk) disable iff (rst) br.valid == exp_d2.br.valid)
    else report_err("br.valid", $sampled(exp_d2.br.valid), $sampled(br.valid));
  a_br_taken: assert property (@(posedge clk) disable iff (rst)
    exp_d2.br.valid |-> br.taken == exp_d2.br.taken)
    else report_err("br.taken", $sampled(exp_d2.br.taken), $sampled(br.taken));

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // rv32i semantics of the integer ops
  function automatic logic [31:0] model_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, $signed(a) < $signed(b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic expect_t writeback(logic [4:0] rd, logic [31:0] r);
    expect_t e;
    e = '0;
    e.wb.valid = (rd != 5'd0);
    e.wb.rd = rd;
    e.wb.data = r;
    if (rd != 5'd0)
      shadow[rd] = r;
    return e;
  endfunction

  task automatic issue(logic [31:0] word, expect_t e);
    @(negedge clk);
    instr = word;
    instr_valid = 1'b1;
    exp_now = e;
    issued++;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid = 1'b0;
      exp_now = '0;
    end
  endtask

  task automatic r_type(logic [2:0] f3, logic alt, logic [4:0] rd, logic [4:0] rs1,
                        logic [4:0] rs2);
    expect_t e;
    e = writeback(rd, model_op(f3, alt, shadow[rs1], shadow[rs2]));
    issue({1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011}, e);
  endtask

  task automatic op_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    expect_t e;
    e = writeback(rd, model_op(f3, f3 == 3'd5 && imm[10], shadow[rs1], sext12(imm)));
    issue({imm, rs1, f3, rd, 7'b0010011}, e);
  endtask

  task automatic store_word(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    expect_t e;
    e = '0;
    e.st.we = 1'b1;
    e.st.addr = shadow[rs1] + sext12(imm);
    e.st.wdata = shadow[rs2];
    issue({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}, e);
  endtask

  task automatic branch_cmp(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
    expect_t e;
    e = '0;
    e.br.valid = 1'b1;
    e.br.taken = (f3 == 3'd0) ? (shadow[rs1] == shadow[rs2]) : (shadow[rs1] != shadow[rs2]);
    issue({7'd0, rs2, rs1, f3, 5'b10000, 7'b1100011}, e);
  endtask

  // full 32-bit constant built in 11/11/10 bit chunks
  task automatic load_reg(logic [4:0] rd, logic [31:0] v);
    op_imm(3'd0, rd, 5'd0, {1'b0, v[31:21]});
    op_imm(3'd1, rd, rd, 12'd11);
    op_imm(3'd6, rd, rd, {1'b0, v[20:10]});
    op_imm(3'd1, rd, rd, 12'd10);
    op_imm(3'd6, rd, rd, {2'b0, v[9:0]});
  endtask

  task automatic end_test(string name);
    idle(3); // drain the pipe
    tests_run++;
    if (errors > test_err0)
      tests_bad++;
    $display("%s: %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin : watchdog
    while (cycles <= 50 * issued + 100) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog: run did not finish within its cycle budget");
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [11:0] imm;
    logic [31:0] r;
    rst = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    exp_now = '0;
    for (int i = 0; i < 32; i++)
      shadow[i] = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    idle(4);
    for (int i = 0; i < 32; i++)
      op_imm(3'd0, 5'(i), 5'(i), 12'd0);
    end_test("reset");

    load_reg(5'd1, $random(seed));
    load_reg(5'd2, $random(seed));
    load_reg(5'd3, $random(seed) | 32'h8000_0000); // negative
    load_reg(5'd4, $random(seed) & 32'h7fff_ffff);
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5) begin
          r_type(3'(f), alt[0], 5'd10, 5'd1, 5'd2);
          r_type(3'(f), alt[0], 5'd11, 5'd3, 5'd4);
          r_type(3'(f), alt[0], 5'd12, 5'd4, 5'd3);
        end
      end
    end
    end_test("r_type");

    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 4; k++) begin
        imm = 12'($random(seed));
        if (f == 1)
          imm = {7'd0, imm[4:0]};
        else if (f == 5)
          imm = {1'b0, k[0], 5'd0, imm[4:0]}; // srli then srai
        else
          imm[11] = k[0];
        op_imm(3'(f), 5'd13, (k < 2) ? 5'd3 : 5'd4, imm);
      end
    end
    op_imm(3'd0, 5'd14, 5'd3, 12'h400); // instr bit 30 set, still addi
    op_imm(3'd0, 5'd15, 5'd14, 12'hc01);
    end_test("op_imm");

    op_imm(3'd0, 5'd6, 5'd0, 12'd5);
    r_type(3'd0, 1'b0, 5'd7, 5'd6, 5'd6);
    r_type(3'd0, 1'b1, 5'd8, 5'd7, 5'd6); // distance 1 and 2
    idle(1);
    r_type(3'd4, 1'b0, 5'd9, 5'd8, 5'd7);
    idle(2);
    r_type(3'd0, 1'b1, 5'd10, 5'd9, 5'd8);
    op_imm(3'd0, 5'd0, 5'd1, 12'd7);     // x0 write dropped
    r_type(3'd0, 1'b0, 5'd11, 5'd0, 5'd0);
    r_type(3'd6, 1'b0, 5'd12, 5'd0, 5'd1);
    for (int k = 0; k < 24; k++) begin
      r = $random(seed);
      r_type(r[2:0], r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5), 5'(r[6:4] + 1),
             5'(r[9:7] + 1), 5'(r[12:10] + 1));
      if (r[13] && r[14])
        idle(1);
    end
    end_test("forwarding");

    store_word(5'd1, 5'd2, 12'hff8);     // negative offset
    store_word(5'd3, 5'd4, 12'h123);
    op_imm(3'd0, 5'd16, 5'd2, 12'h05a);
    store_word(5'd16, 5'd16, 12'h004);
    store_word(5'd0, 5'd16, 12'h7fc);
    end_test("store");

    op_imm(3'd0, 5'd17, 5'd2, 12'd0);
    branch_cmp(3'd0, 5'd17, 5'd2);
    branch_cmp(3'd1, 5'd17, 5'd2);
    branch_cmp(3'd0, 5'd1, 5'd2);
    branch_cmp(3'd1, 5'd1, 5'd2);
    branch_cmp(3'd0, 5'd0, 5'd0);
    // unsupported words leave every output quiet
    issue(32'h0000_2083, '0);             // lw
    issue(32'h0000_006f, '0);             // jal
    issue(32'h1234_50b7, '0);             // lui
    issue({7'd0, 5'd2, 5'd1, 3'b000, 5'd4, 7'b0100011}, '0);
    issue({7'd0, 5'd2, 5'd1, 3'b100, 5'd0, 7'b1100011}, '0);
    end_test("branch");

    $display("%0d tests run, %0d with errors, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== design/exec_core.sv ====
// integer execute subsystem top
`timescale 1ns/100ps

module exec_core
  import exec_pkg::*;
#(
  parameter int xlen = XLEN_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] instr,
  input  logic        instr_valid,
  output wb_t         wb,
  output store_t      st,
  output branch_t     br
);

  decoded_t        dec;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  main_decode #(
    .xlen (xlen)
  ) u_main_decode (
    .instr       (instr),
    .instr_valid (instr_valid),
    .dec         (dec)
  );

  reg_file #(
    .xlen (xlen)
  ) u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)        // write port fed from ex/wb
  );

  exec_stage #(
    .xlen (xlen)
  ) u_exec_stage (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .st       (st),
    .br       (br)
  );

endmodule

// ==== design/exec_stage.sv ====
// execute stage with id/ex and ex/wb registers
`timescale 1ns/100ps

module exec_stage
  import exec_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  decoded_t        dec,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output wb_t             wb,
  output store_t          st,
  output branch_t         br
);

  decoded_t        ex_q;
  logic [xlen-1:0] rs1_q;
  logic [xlen-1:0] rs2_q;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] fwd_b;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            alu_zero;
  alu_ctrl_e       ctl;
  logic            fwd_a_hit;
  logic            fwd_b_hit;

  wb_t             wb_q;
  store_t          st_q;
  branch_t         br_q;

  // id/ex register
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_q.valid     <= 1'b0;
      ex_q.reg_write <= 1'b0;
      ex_q.is_store  <= 1'b0;
      ex_q.is_branch <= 1'b0;
    end else begin
      ex_q  <= dec;
      rs1_q <= rs1_data;
      rs2_q <= rs2_data;
    end
  end

  // forward from the instruction just ahead, never for x0
  assign fwd_a_hit = wb_q.valid && ex_q.rs1 != 5'd0 && wb_q.rd == ex_q.rs1;
  assign fwd_b_hit = wb_q.valid && ex_q.rs2 != 5'd0 && wb_q.rd == ex_q.rs2;

  assign op_a  = fwd_a_hit ? wb_q.data : rs1_q;
  assign fwd_b = fwd_b_hit ? wb_q.data : rs2_q;
  assign op_b  = ex_q.use_imm ? ex_q.imm : fwd_b;

  alu_ctrl u_alu_ctrl (
    .alu_op (ex_q.alu_op),
    .func   (ex_q.func),
    .ctl    (ctl)
  );

  alu #(
    .xlen (xlen)
  ) u_alu (
    .a      (op_a),
    .b      (op_b),
    .ctl    (ctl),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // ex/wb register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q.valid <= 1'b0;
      st_q.we    <= 1'b0;
      br_q.valid <= 1'b0;
    end else begin
      wb_q.valid <= ex_q.valid && ex_q.reg_write && ex_q.rd != 5'd0;
      wb_q.rd    <= ex_q.rd;
      wb_q.data  <= alu_result;
      st_q.we    <= ex_q.valid && ex_q.is_store;
      st_q.addr  <= alu_result;
      st_q.wdata <= fwd_b;
      br_q.valid <= ex_q.valid && ex_q.is_branch;
      br_q.taken <= (ex_q.func[2:0] == f3_bne) ? !alu_zero : alu_zero;
    end
  end

  assign wb = wb_q;
  assign st = st_q;
  assign br = br_q;

  a_one_result: assert property (@(posedge clk) disable iff (rst)
    $onehot0({wb_q.valid, st_q.we, br_q.valid}))
    else $error("exec_stage: more than one result valid");

endmodule

// ==== design/reg_file.sv ====
// 32-entry register file
`timescale 1ns/100ps

module reg_file
  import exec_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  input  wb_t             wb
);

  logic [xlen-1:0] regs [1:31]; // x0 not stored

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wb.valid && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 :
                    (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1]; // write-through
  assign rs2_data = (rs2 == 5'd0) ? '0 :
                    (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

  // x0 stays zero even while a writeback targets it
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((rs1 == 5'd0) |-> (rs1_data == '0)) and ((rs2 == 5'd0) |-> (rs2_data == '0)))
    else $error("reg_file: x0 read nonzero");

endmodule

// ==== design/main_decode.sv ====
// main instruction decoder
`timescale 1ns/100ps

module main_decode
  import exec_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic [31:0] instr,
  input  logic        instr_valid,
  output decoded_t    dec
);

  logic [2:0]      funct3;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;

  assign funct3 = instr[14:12];

  assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};

  always_comb begin
    dec           = '0;
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.rd        = instr[11:7];
    dec.alu_op    = alu_op_add;
    dec.func      = {instr[30], funct3};
    if (instr_valid) begin
      case (instr[6:0])
        opc_op: begin
          dec.valid     = 1'b1;
          dec.reg_write = 1'b1;
          dec.alu_op    = alu_op_func;
        end
        opc_op_imm: begin
          dec.valid     = 1'b1;
          dec.reg_write = 1'b1;
          dec.use_imm   = 1'b1;
          dec.imm       = imm_i;
          dec.alu_op    = alu_op_func;
          // bit 30 is only an opcode bit for srli/srai
          if (funct3 != f3_srl_sra)
            dec.func[3] = 1'b0;
        end
        opc_store: begin
          if (funct3 == f3_sw) begin // sw only
            dec.valid    = 1'b1;
            dec.is_store = 1'b1;
            dec.use_imm  = 1'b1;
            dec.imm      = imm_s;
          end
        end
        opc_branch: begin
          if (funct3 == f3_beq || funct3 == f3_bne) begin
            dec.valid     = 1'b1;
            dec.is_branch = 1'b1;
            dec.imm       = imm_b; // target math lives outside
            dec.alu_op    = alu_op_sub;
          end
        end
        default: ; // illegal, dropped
      endcase
    end
  end

  always_comb begin
    assert ($onehot0({dec.reg_write, dec.is_store, dec.is_branch}))
      else $error("main_decode: more than one result kind for %h", instr);
  end

endmodule

// ==== design/alu_ctrl.sv ====
// alu control decode
`timescale 1ns/100ps

module alu_ctrl
  import exec_pkg::*;
(
  input  alu_op_e    alu_op,
  input  logic [3:0] func,
  output alu_ctrl_e  ctl
);

  always_comb begin
    case (alu_op)
      alu_op_add: ctl = alu_add;
      alu_op_sub: ctl = alu_sub;
      alu_op_func: begin
        case (func)
          {1'b0, f3_add_sub}: ctl = alu_add;
          {1'b1, f3_add_sub}: ctl = alu_sub;
          {1'b0, f3_and}:     ctl = alu_and;
          {1'b0, f3_or}:      ctl = alu_or;
          {1'b0, f3_xor}:     ctl = alu_xor;
          {1'b0, f3_sll}:     ctl = alu_sll;
          {1'b0, f3_slt}:     ctl = alu_slt;
          {1'b0, f3_sltu}:    ctl = alu_sltu;
          {1'b0, f3_srl_sra}: ctl = alu_srl;
          {1'b1, f3_srl_sra}: ctl = alu_sra;
          default:            ctl = alu_add;
        endcase
      end
      default: ctl = alu_add;
    endcase
  end

endmodule

// ==== design/alu.sv ====
// integer alu
`timescale 1ns/100ps

module alu
  import exec_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  alu_ctrl_e       ctl,
  output logic [xlen-1:0] result,
  output logic            zero
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (ctl)
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      alu_sll:  result = a << shamt;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt; // sign fill
      alu_nor:  result = ~(a | b);
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// ==== design/exec_pkg.sv ====
// execute subsystem shared types
// opcodes, alu encodings and result structs

package exec_pkg;

  localparam int XLEN_DEFAULT = 32;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011
  } opcode_e;

  // alu-op class from the main decoder
  typedef enum logic [1:0] {
    alu_op_add  = 2'b00, // address arithmetic
    alu_op_sub  = 2'b01, // branch compare
    alu_op_func = 2'b10  // funct bits decide
  } alu_op_e;

  typedef enum logic [3:0] {
    alu_and  = 4'b0000,
    alu_or   = 4'b0001,
    alu_xor  = 4'b0010,
    alu_add  = 4'b0011,
    alu_sub  = 4'b0100,
    alu_slt  = 4'b0101,
    alu_sltu = 4'b0110,
    alu_sll  = 4'b0111,
    alu_srl  = 4'b1000,
    alu_sra  = 4'b1001,
    alu_nor  = 4'b1010  // kept for encoding, no instruction uses it
  } alu_ctrl_e;

  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_sltu    = 3'b011,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } funct3_e;

  // branch funct3 shares values with the alu table
  localparam funct3_e f3_beq = f3_add_sub;
  localparam funct3_e f3_bne = f3_sll;
  localparam logic [2:0] f3_sw = 3'b010;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic        reg_write;
    logic        is_store;
    logic        is_branch;
    alu_op_e     alu_op;
    logic [3:0]  func;     // {instr[30], funct3}
  } decoded_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } store_t;

  typedef struct packed {
    logic valid;
    logic taken;
  } branch_t;

endpackage
